/* vlog.f */
verilog/fpFormatPkg.sv
verilog/fpConvPkg.sv
verilog/fpFieldsIf.sv
verilog/cntlz64.sv
verilog/fpDecomp.sv
verilog/f32ToF80.sv
verilog/f80ToF32.sv
verilog/fpConvUnit.sv
verif/clkGen.sv
verif/fpConvTb.sv

/* run.sh */
#!/bin/sh
# build the converter testbench with Verilator, run it, then scan the log
verilator --binary --timing --assert -f vlog.f --top-module fpConvTb -o fpConvSim \
  && { ./obj_dir/fpConvSim > sim.log 2>&1 || true; } \
  && cat sim.log \
  && ! grep -q "Testbench failed" sim.log \
  && echo "run.sh: simulation clean" \
  || { echo "run.sh: simulation reported failure"; exit 1; }

/* verif/fpConvTb.sv */
`timescale 1ns/1ps

module fpConvTb import fpFormatPkg::*, fpConvPkg::*; ();

  // requests per test group
  localparam int N_NORM = 200;
  localparam int N_DEN = 100;
  localparam int N_SPECIAL = 20;
  localparam int N_RT = 200;
  localparam int N_RND = 200;
  localparam int N_RANGE = 40;
  localparam int N_NEAR = 100;
  localparam int N_UNNORM = 40;
  localparam int REQ_TOTAL = N_NORM + 2 + N_DEN + 4 + 2 * N_SPECIAL + 2 * N_RT + N_RND + 1
    + 2 * N_RANGE + N_NEAR + N_UNNORM;
  // margin covers idle gaps in the first group plus reset and drain
  localparam int TIMEOUT_CYCLES = REQ_TOTAL + N_NORM + 500;

  logic clk;
  logic rstN;
  logic inValid;
  fpConvOp_t op;
  logic [F80_WORD_W-1:0] a;
  logic outValid;
  logic [F80_WORD_W-1:0] o;

  logic [31:0] rngState;
  // expected results and their due cycles in request order
  logic [F80_WORD_W-1:0] expQ[$];
  int dueQ[$];
  int cycleCnt = 0;
  int resultCnt = 0;

  clkGen #(.PERIOD_NS(20), .RESET_CYCLES(2)) clkGen0 (.clk(clk), .rstN(rstN));

  fpConvUnit #(.LATENCY(CONV_LATENCY)) dut0 (
    .clk(clk),
    .rstN(rstN),
    .inValid(inValid),
    .op(op),
    .a(a),
    .outValid(outValid),
    .o(o)
  );

  // ====================================================================
  // helpers
  // ====================================================================

  task automatic stopRun(input string why);
    $display("%s", why);
    $display("Testbench failed");
    $fatal(1, "run stopped at %0t", $time);
  endtask

  function automatic logic [31:0] xorshift32();
    logic [31:0] x;
    x = rngState;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    rngState = x;
    return x;
  endfunction

  function automatic logic [79:0] randExt();
    return {16'(xorshift32()), xorshift32(), xorshift32()};
  endfunction

  // single to extended conversion model
  function automatic logic [79:0] refUp(input logic [31:0] s);
    logic [63:0] m;
    int ex;
    if (s[30:0] == 31'd0) return {s[31], 79'd0};
    if (s[30:23] == 8'hff && s[22:0] == 23'd0) return {s[31], 15'h7fff, 1'b1, 63'd0};
    // NaN payload moves up with the quiet and integer bits on
    if (s[30:23] == 8'hff) return {s[31], 15'h7fff, 2'b11, s[21:0], 40'd0};
    if (s[30:23] != 8'd0) begin
      ex = int'(s[30:23]) + 16383 - 127;
      return {s[31], ex[14:0], 1'b1, s[22:0], 40'd0};
    end
    // walk the top set bit of a denormal up to the integer bit
    m = {s[22:0], 41'd0};
    ex = 16383 - 126 - 1;
    while (!m[63]) begin
      m = m << 1;
      ex = ex - 1;
    end
    return {s[31], ex[14:0], m};
  endfunction

  // extended to single with nearest-even rounding
  function automatic logic [31:0] refDown(input logic [79:0] x);
    logic [63:0] m;
    logic [23:0] sig;
    logic [24:0] rnd;
    logic guard;
    logic sticky;
    int ee;
    int be;
    m = x[63:0];
    if (x[78:64] == 15'h7fff && m[62:0] != 63'd0) return {x[79], 8'hff, 1'b1, m[61:40]};
    if (x[78:64] == 15'h7fff) return {x[79], 8'hff, 23'd0};
    if (m == 64'd0) return {x[79], 31'd0};
    // exponent code 0 weighs like 1 before normalizing by value
    ee = (x[78:64] == 15'd0) ? 1 : int'(x[78:64]);
    while (!m[63]) begin
      m = m << 1;
      ee = ee - 1;
    end
    be = ee - 16383 + 127;
    if (be >= 255) return {x[79], 8'hff, 23'd0};
    if (1 - be > 25) return {x[79], 31'd0};
    // shift into denormal range one bit per step into sticky
    sticky = 1'b0;
    for (int k = be; k < 1; k++) begin
      sticky = sticky | m[0];
      m = m >> 1;
    end
    sig = m[63:40];
    guard = m[39];
    sticky = sticky | (m[38:0] != 39'd0);
    rnd = {1'b0, sig} + 25'(guard & (sticky | sig[0]));
    // a denormal rounding up to 2^23 lands on the smallest normal
    if (be < 1) return {x[79], 7'd0, rnd[23:0]};
    if (rnd[24]) begin
      be = be + 1;
      rnd = rnd >> 1;
    end
    if (be >= 255) return {x[79], 8'hff, 23'd0};
    return {x[79], be[7:0], rnd[22:0]};
  endfunction

  // one request per falling edge with its expected result and due cycle
  task automatic sendReq(input fpConvOp_t kind, input logic [79:0] operand,
                         input logic [79:0] want);
    @(negedge clk);
    inValid = 1'b1;
    op = kind;
    a = operand;
    expQ.push_back(want);
    dueQ.push_back(cycleCnt + CONV_LATENCY);
  endtask

  task automatic sendUp(input logic [31:0] s);
    sendReq(CONV_F32_TO_F80, {48'd0, s}, refUp(s));
  endtask

  task automatic sendDown(input logic [79:0] x);
    sendReq(CONV_F80_TO_F32, x, {48'd0, refDown(x)});
  endtask

  task automatic idleCycles(input int n);
    repeat (n) begin
      @(negedge clk);
      inValid = 1'b0;
    end
  endtask

  // ====================================================================
  // checking on the falling edge where outputs are settled
  // ====================================================================

  always @(posedge clk) begin
    cycleCnt = cycleCnt + 1;
    if (cycleCnt > TIMEOUT_CYCLES) begin
      stopRun($sformatf("timeout, run still going after %0d cycles", TIMEOUT_CYCLES));
    end
  end

  always @(negedge clk) begin
    if (rstN !== 1'b1) begin
      if (cycleCnt > 0) begin
        assert (!outValid) else stopRun("outValid was high during reset");
      end
    end else if (outValid) begin
      assert (expQ.size() != 0) begin
        assert (dueQ[0] == cycleCnt) begin
          assert (o == expQ[0]) begin
            void'(expQ.pop_front());
            void'(dueQ.pop_front());
            resultCnt = resultCnt + 1;
          end else begin
            stopRun($sformatf("Error at %0t: result %h, expected %h", $time, o, expQ[0]));
          end
        end else begin
          stopRun($sformatf("result came in cycle %0d, its request was due in cycle %0d",
            cycleCnt, dueQ[0]));
        end
      end else begin
        stopRun("outValid went high with no request outstanding");
      end
    end else begin
      // no result now so none may be overdue
      assert (expQ.size() == 0 || dueQ[0] > cycleCnt) begin
        assert (resultCnt != 0 || o == '0) else begin
          stopRun($sformatf("Error at %0t: o is %h before any result, expected zero",
            $time, o));
        end
      end else begin
        stopRun($sformatf("no result in cycle %0d although a request was due", cycleCnt));
      end
    end
  end

  // ====================================================================
  // stimulus
  // ====================================================================

  initial begin
    logic [31:0] s;
    logic [79:0] x;
    inValid = 1'b0;
    op = CONV_F32_TO_F80;
    a = '0;
    rngState = 32'h5ab6;
    while (rstN !== 1'b1) @(negedge clk);
    // outValid has to stay low through a quiet stretch
    idleCycles(6);

    // random normal singles with some gaps between requests
    for (int n = 0; n < N_NORM; n++) begin
      s = xorshift32();
      s[30:23] = 8'(1 + xorshift32() % 254);
      sendUp(s);
      if (xorshift32() % 4 == 0) idleCycles(1);
    end

    // signed zeros and denormals of every depth
    sendUp(32'h0000_0000);
    sendUp(32'h8000_0000);
    for (int n = 0; n < N_DEN; n++) begin
      s = xorshift32() & 32'h807f_ffff;
      s[22:0] = s[22:0] >> (xorshift32() % 23);
      if (s[22:0] == 23'd0) s[0] = 1'b1;
      sendUp(s);
    end

    // infinities and NaNs both ways
    sendUp(32'h7f80_0000);
    sendUp(32'hff80_0000);
    sendDown({1'b0, F80_EXP_MAX, 1'b1, 63'd0});
    sendDown({1'b1, F80_EXP_MAX, 1'b1, 63'd0});
    for (int n = 0; n < N_SPECIAL; n++) begin
      // random bit 22 gives quiet and signalling NaNs
      s = xorshift32() | 32'h7f80_0000;
      if (s[22:0] == 23'd0) s[0] = 1'b1;
      sendUp(s);
      x = randExt();
      x[78:63] = {F80_EXP_MAX, 1'b1};
      if (x[62:0] == 63'd0) x[0] = 1'b1;
      sendDown(x);
    end

    // round trip expects the original single back
    for (int n = 0; n < N_RT; n++) begin
      s = xorshift32();
      if (n % 4 == 0) s[30:23] = 8'd0;
      if (s[30:23] == 8'hff) s[22:0] = 23'd0;
      x = refUp(s);
      sendUp(s);
      sendReq(CONV_F80_TO_F32, x, {48'd0, s});
    end

    // extra low bits with every eighth one an exact tie
    for (int n = 0; n < N_RND; n++) begin
      s = xorshift32();
      s[30:23] = 8'(2 + xorshift32() % 252);
      x = refUp(s);
      x[39:0] = {8'(xorshift32()), xorshift32()};
      if (n % 8 == 0) x[39:0] = 40'h80_0000_0000;
      sendDown(x);
    end
    // largest exponent with a full significand rounds over to infinity
    sendDown({1'b0, 15'(16383 + 127), 64'hffff_ffff_ffff_ffff});

    // beyond the single range and then deep underflow
    for (int n = 0; n < N_RANGE; n++) begin
      x = randExt();
      x[63] = 1'b1;
      x[78:64] = 15'(16383 + 128 + xorshift32() % 16000);
      sendDown(x);
      x[78:64] = 15'(xorshift32() % 16232);
      sendDown(x);
    end

    // near underflow covers single denormals and the normal boundary
    for (int n = 0; n < N_NEAR; n++) begin
      x = randExt();
      x[63] = 1'b1;
      x[78:64] = 15'(16383 - 151 + xorshift32() % 26);
      sendDown(x);
    end

    // unnormals and pseudo-denormals convert by value
    for (int n = 0; n < N_UNNORM; n++) begin
      x = randExt();
      x[63:0] = {1'b0, x[62:0]} >> (xorshift32() % 40);
      x[78:64] = 15'(xorshift32() % 16400);
      sendDown(x);
    end

    idleCycles(CONV_LATENCY + 4);
    if (expQ.size() == 0) begin
      $display("Testbench passed");
      $finish;
    end else begin
      stopRun($sformatf("%0d results never arrived", expQ.size()));
    end
  end

endmodule

/* verif/clkGen.sv */
`timescale 1ns/1ps

// free running clock plus power-on reset
module clkGen #(
  parameter int PERIOD_NS = 20,
  parameter int RESET_CYCLES = 2
) (
  output logic clk,
  output logic rstN
);

  initial begin
    clk = 1'b0;
    forever #(PERIOD_NS / 2) clk = ~clk;
  end

  // reset spans the first rising edges, released on a falling edge
  initial begin
    rstN = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    rstN <= 1'b1;
  end

endmodule

/* verilog/fpConvUnit.sv */
`timescale 1ns/1ps

module fpConvUnit import fpFormatPkg::*, fpConvPkg::*; #(
  parameter int LATENCY = CONV_LATENCY
) (
  input logic clk,
  input logic rstN,
  input logic inValid,
  input fpConvOp_t op,
  input logic [F80_WORD_W-1:0] a,
  output logic outValid,
  output logic [F80_WORD_W-1:0] o
);

  // valid strobe per pipeline stage
  logic [LATENCY-1:0] validPipe;

  // stage 1 request
  fpConvOp_t regOp;
  logic [F80_WORD_W-1:0] regA;

  // converter results
  logic [F80_WORD_W-1:0] extRes;
  logic [F32_WORD_W-1:0] sglRes;
  logic [F80_WORD_W-1:0] result;

  // ====================================================================
  // stage 1 input register
  // ====================================================================

  always_ff @(posedge clk) begin
    if (!rstN) begin
      validPipe <= '0;
    end else begin
      validPipe <= {validPipe[LATENCY-2:0], inValid};
    end
  end

  // operand and opcode load without reset
  always_ff @(posedge clk) begin
    if (inValid) begin
      regOp <= op;
      regA <= a;
    end
  end

  // ====================================================================
  // decomposers and converters
  // ====================================================================

  fpFieldsIf #(.EXP_W(F32_EXP_W), .MAN_W(F32_MAN_W)) f32Fields ();
  fpFieldsIf #(.EXP_W(F80_EXP_W), .MAN_W(F80_MAN_W)) f80Fields ();

  // single operand lives in the low word
  fpDecomp #(.WID(F32_WORD_W)) decomp32 (
    .i(regA[F32_WORD_W-1:0]),
    .fields(f32Fields.src)
  );

  fpDecomp #(.WID(F80_WORD_W)) decomp80 (
    .i(regA),
    .fields(f80Fields.src)
  );

  f32ToF80 upConv (
    .fields(f32Fields.dst),
    .o(extRes)
  );

  f80ToF32 downConv (
    .fields(f80Fields.dst),
    .o(sglRes)
  );

  // single result zero extended
  assign result = (regOp == CONV_F32_TO_F80) ?
    extRes : {{(F80_WORD_W-F32_WORD_W){1'b0}}, sglRes};

  // ====================================================================
  // stage 2 output register
  // ====================================================================

  // o reads zero until the first result arrives
  // then holds the last result between requests
  always_ff @(posedge clk) begin
    if (!rstN) begin
      o <= '0;
    end else if (validPipe[0]) begin
      o <= result;
    end
  end

  assign outValid = validPipe[LATENCY-1];

endmodule

/* verilog/f80ToF32.sv */
`timescale 1ns/1ps

module f80ToF32 import fpFormatPkg::*; (
  fpFieldsIf.dst fields,
  output logic [F32_WORD_W-1:0] o
);

  // normalization
  logic [6:0] lz;
  logic [F80_MAN_W-1:0] normMan;
  logic [F80_EXP_W-1:0] effExp;

  // rebiased exponent and denormal shift, both signed
  logic signed [17:0] rebExp;
  logic signed [17:0] shiftReq;
  logic tiny;
  logic [4:0] shAmt;

  // rounding
  logic [127:0] wide;
  logic [23:0] sig24;
  logic guardBit;
  logic stickyBit;
  logic roundUp;
  logic [F32_EXP_W-1:0] expField;
  logic [30:0] magRes;

  logic isNan;

  // ====================================================================
  // normalize the significand
  // ====================================================================

  // unnormals and pseudo-denormals go by value
  cntlz64 lzc (
    .i(fields.man),
    .cnt(lz)
  );

  assign normMan = fields.man << lz;

  // zero exponent field behaves like exponent 1 in extended
  assign effExp = fields.xz ? F80_EXP_W'(1) : fields.exp;

  // exponent in single bias after normalization
  assign rebExp = 18'(effExp) - 18'(lz) - 18'(F80_F32_REBIAS);

  // ====================================================================
  // denormal alignment
  // ====================================================================

  // below exponent 1 the result is a single denormal
  assign tiny = (rebExp < 18'sd1);
  assign shiftReq = 18'sd1 - rebExp;
  assign shAmt = tiny ? shiftReq[4:0] : 5'd0;

  // 64 spare zeros below keep every shifted-out bit for sticky
  assign wide = {normMan, 64'd0} >> shAmt;
  assign sig24 = wide[127:104];
  assign guardBit = wide[103];
  assign stickyBit = |wide[102:0];

  // ====================================================================
  // round to nearest even
  // ====================================================================

  assign roundUp = guardBit & (stickyBit | sig24[0]);
  assign expField = tiny ? '0 : rebExp[F32_EXP_W-1:0];

  // carry out of the fraction walks into the exponent
  // this renormalizes, lifts a denormal to the smallest normal
  // and turns exponent 254 into infinity
  assign magRes = {expField, sig24[F32_MAN_W-1:0]} + 31'(roundUp);

  // quiet bit is man[62], remaining fraction below it
  assign isNan = fields.qnan | (fields.xinf & (|fields.man[F80_MAN_W-3:0]));

  // ====================================================================
  // result select
  // ====================================================================

  always_comb begin
    if (isNan) begin
      // top 22 payload bits kept
      o = {fields.sgn, F32_EXP_MAX, 1'b1, fields.man[61:40]};
    end else if (fields.xinf) begin
      o = {fields.sgn, F32_EXP_MAX, 23'd0};
    end else if (fields.vz) begin
      o = {fields.sgn, 31'd0};
    end else if (rebExp >= 18'sd255) begin
      // overflow to signed infinity
      o = {fields.sgn, F32_EXP_MAX, 23'd0};
    end else if (shiftReq > 18'sd25) begin
      // deep underflow, too small even to round up
      o = {fields.sgn, 31'd0};
    end else begin
      o = {fields.sgn, magRes};
    end
  end

endmodule

/* verilog/f32ToF80.sv */
`timescale 1ns/1ps

module f32ToF80 import fpFormatPkg::*; (
  fpFieldsIf.dst fields,
  output logic [F80_WORD_W-1:0] o
);

  // fraction placed at the top of a 64-bit word
  logic [F80_MAN_W-1:0] fracTop;
  // leading zeros of the fraction
  logic [6:0] lz;
  logic isNan;

  // result fields
  logic sgnOut;
  logic [F80_EXP_W-1:0] expOut;
  logic [F80_MAN_W-1:0] manOut;

  assign fracTop = {fields.man, 41'd0};

  cntlz64 lzc (
    .i(fracTop),
    .cnt(lz)
  );

  // quiet NaNs flagged directly
  // signalling ones still have some other fraction bit set
  assign isNan = fields.qnan | (fields.xinf & (|fields.man[F32_MAN_W-2:0]));

  assign o = {sgnOut, expOut, manOut};

  // ====================================================================
  // conversion by operand class
  // ====================================================================

  always_comb begin
    // sign passes through in every case
    sgnOut = fields.sgn;
    if (fields.vz) begin
      // signed zero
      expOut = '0;
      manOut = '0;
    end else if (isNan) begin
      // payload kept at the top, quiet bit forced on
      expOut = F80_EXP_MAX;
      manOut = {2'b11, fields.man[F32_MAN_W-2:0], 40'd0};
    end else if (fields.xinf) begin
      // infinity needs the integer bit set in extended
      expOut = F80_EXP_MAX;
      manOut = {1'b1, 63'd0};
    end else if (fields.xz) begin
      // denormal input
      // value is 0.frac * 2^-126, range fits easily in extended
      // move the top set bit up to the integer bit position
      expOut = F80_EXP_W'(F80_F32_REBIAS) - F80_EXP_W'(lz);
      manOut = fracTop << lz;
    end else begin
      // normal input
      // rebias and make the hidden bit explicit
      expOut = F80_EXP_W'(fields.exp) + F80_EXP_W'(F80_F32_REBIAS);
      manOut = {1'b1, fields.man, 40'd0};
    end
  end

endmodule

/* verilog/fpDecomp.sv */
`timescale 1ns/1ps

module fpDecomp import fpFormatPkg::*; #(
  parameter int WID = 32
) (
  input logic [WID-1:0] i,
  fpFieldsIf.src fields
);

  // field layout picked by the word width
  localparam bit IS_F80 = (WID == F80_WORD_W);
  localparam int EXP_W = IS_F80 ? F80_EXP_W : F32_EXP_W;
  localparam int MAN_W = WID - 1 - EXP_W;
  // quiet bit sits just below the explicit integer bit in extended
  // and at the top of the fraction in single
  localparam int QBIT = IS_F80 ? MAN_W - 2 : MAN_W - 1;
  localparam logic [EXP_W-1:0] EXP_MAX =
    IS_F80 ? EXP_W'(F80_EXP_MAX) : EXP_W'(F32_EXP_MAX);

  logic [EXP_W-1:0] expField;
  logic [MAN_W-1:0] manField;
  logic expOnes;
  logic expZero;
  logic manZero;

  // ====================================================================
  // raw slicing
  // ====================================================================

  assign expField = i[WID-2 -: EXP_W];
  assign manField = i[MAN_W-1:0];

  assign fields.sgn = i[WID-1];
  assign fields.exp = expField;
  // integer bit stays in man for extended
  assign fields.man = manField;

  // ====================================================================
  // class flags
  // ====================================================================

  assign expOnes = (expField == EXP_MAX);
  assign expZero = (expField == '0);
  assign manZero = (manField == '0);

  assign fields.xinf = expOnes;
  assign fields.xz = expZero;

  // single is zero only with a zero exponent
  // extended is zero whenever the full significand is clear,
  // so unnormals with no bits set count as zero too
  assign fields.vz = IS_F80 ? (~expOnes & manZero) : (expZero & manZero);

  assign fields.qnan = expOnes & manField[QBIT];

endmodule

/* verilog/cntlz64.sv */
`timescale 1ns/1ps

module cntlz64 (
  input logic [63:0] i,
  output logic [6:0] cnt
);

  // halves kept at each level of the tree
  logic [31:0] s32;
  logic [15:0] s16;
  logic [7:0] s8;
  logic [3:0] s4;
  logic [1:0] s2;
  // count bits, msb decided first
  logic [5:0] pos;
  logic allZero;

  // ====================================================================
  // binary priority tree
  // ====================================================================

  // each level asks whether the upper half is empty
  // if so that half adds to the count and the lower half moves on
  assign pos[5] = ~|i[63:32];
  assign s32 = pos[5] ? i[31:0] : i[63:32];

  assign pos[4] = ~|s32[31:16];
  assign s16 = pos[4] ? s32[15:0] : s32[31:16];

  assign pos[3] = ~|s16[15:8];
  assign s8 = pos[3] ? s16[7:0] : s16[15:8];

  assign pos[2] = ~|s8[7:4];
  assign s4 = pos[2] ? s8[3:0] : s8[7:4];

  assign pos[1] = ~|s4[3:2];
  assign s2 = pos[1] ? s4[1:0] : s4[3:2];

  // last pair, top bit clear means one more zero
  assign pos[0] = ~s2[1];

  // all zero word reports the full width
  assign allZero = ~|i;
  assign cnt = allZero ? 7'd64 : {1'b0, pos};

endmodule

/* verilog/fpFieldsIf.sv */
`timescale 1ns/1ps

// decomposed fields of one floating-point operand
interface fpFieldsIf #(
  parameter int EXP_W = 8,
  parameter int MAN_W = 23
);

  // sign bit
  logic sgn;
  // biased exponent as stored
  logic [EXP_W-1:0] exp;
  // stored significand
  logic [MAN_W-1:0] man;
  // exponent all ones
  logic xinf;
  // exponent all zeros
  logic xz;
  // operand value is zero
  logic vz;
  // NaN with the quiet bit set
  logic qnan;

  // decomposer side
  modport src (output sgn, exp, man, xinf, xz, vz, qnan);

  // converter side
  modport dst (input sgn, exp, man, xinf, xz, vz, qnan);

endinterface

/* verilog/fpConvPkg.sv */
package fpConvPkg;

  // ====================================================================
  // conversion opcodes
  // ====================================================================

  // one bit selects the direction of the conversion
  typedef enum logic {
    // single in the low 32 bits, extended result
    CONV_F32_TO_F80 = 1'b0,
    // extended in, single result in the low 32 bits
    CONV_F80_TO_F32 = 1'b1
  } fpConvOp_t;

  // ====================================================================
  // pipeline constants
  // ====================================================================

  // cycles from the edge that samples a request to outValid
  // one input register stage plus one output register stage
  localparam int CONV_LATENCY = 2;

endpackage

/* verilog/fpFormatPkg.sv */
package fpFormatPkg;

  // ====================================================================
  // single precision layout
  // ====================================================================

  // total width of a single operand
  localparam int F32_WORD_W = 32;
  // biased exponent field
  localparam int F32_EXP_W = 8;
  // stored fraction, hidden bit not included
  localparam int F32_MAN_W = 23;
  // exponent bias
  localparam int F32_BIAS = 127;
  // all ones exponent marks infinity or NaN
  localparam logic [F32_EXP_W-1:0] F32_EXP_MAX = '1;

  // ====================================================================
  // x87 double-extended layout
  // ====================================================================

  // total width of an extended operand, also the data path width
  localparam int F80_WORD_W = 80;
  // biased exponent field
  localparam int F80_EXP_W = 15;
  // significand with explicit integer bit at the top
  localparam int F80_MAN_W = 64;
  // exponent bias
  localparam int F80_BIAS = 16383;
  // all ones exponent marks infinity or NaN
  localparam logic [F80_EXP_W-1:0] F80_EXP_MAX = '1;

  // ====================================================================
  // cross-format constants
  // ====================================================================

  // difference of the biases
  // added going up in precision, removed coming back down
  localparam int F80_F32_REBIAS = F80_BIAS - F32_BIAS;

endpackage
